// File: build.f
source/core_ctrl_pkg.sv
source/video_pkg.sv
source/input_sync.sv
source/core_settings.sv
source/joy_map.sv
source/overlay_blend.sv
source/video_out.sv
source/vectrex_io_top.sv
tb/vectrex_io_checker.sv
tb/tb_vectrex_io.sv

// File: source/core_ctrl_pkg.sv
/*
  Core control definitions: bridge register map of the settings block,
  controller key bit positions and controller word types.
*/
`default_nettype none

package core_ctrl_pkg;

  //////////////////////////////////////////////////
  // bridge register map
  //////////////////////////////////////////////////
  localparam logic [31:0] addr_persistence = 32'h8000_0000; // beam persistence, 4 bits
  localparam logic [31:0] addr_overburn    = 32'h9000_0000; // overburn flag, data bit 0
  localparam logic [31:0] addr_show_bg     = 32'hA000_0000; // overlay enable, data bit 0

  localparam int persist_w = 4;

  //////////////////////////////////////////////////
  // controller words
  //////////////////////////////////////////////////
  typedef logic [31:0] cont_key_t; // key bitmap from host
  typedef logic [31:0] cont_joy_t; // byte 0 stick x, byte 1 stick y
  typedef logic [7:0]  pot_t;      // pot value seen by core

  // key bitmap bit positions
  localparam int key_up    = 0;
  localparam int key_down  = 1;
  localparam int key_left  = 2;
  localparam int key_right = 3;
  localparam int key_a     = 4;
  localparam int key_b     = 5;
  localparam int key_x     = 6;
  localparam int key_y     = 7;

  // signed stick value to unsigned pot, centre at mid scale
  localparam pot_t pot_center = 8'd128;

endpackage

`default_nettype wire

// File: source/core_settings.sv
/*
  Core settings registers. Host writes over the bridge bus set
  beam persistence, overburn and overlay enable.
*/
`timescale 1ns/1ps
`default_nettype none

module core_settings (
  input  wire         clk_24,
  input  wire         rst_n,
  input  wire  [31:0] bridge_addr,
  input  wire         bridge_wr,      // one cycle per write
  input  wire  [31:0] bridge_wr_data,
  output logic [core_ctrl_pkg::persist_w-1:0] cs_persistence,
  output logic        cs_overburn,
  output logic        show_bg
);

  // exact address match, anything else dropped
  logic hit_persist;
  logic hit_overburn;
  logic hit_show_bg;

  assign hit_persist  = bridge_wr && (bridge_addr == core_ctrl_pkg::addr_persistence);
  assign hit_overburn = bridge_wr && (bridge_addr == core_ctrl_pkg::addr_overburn);
  assign hit_show_bg  = bridge_wr && (bridge_addr == core_ctrl_pkg::addr_show_bg);

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk_24) begin
    if (!rst_n) begin
      cs_persistence <= '0;
      cs_overburn    <= 1'b0;
      show_bg        <= 1'b0;
    end else begin
      if (hit_persist)
        cs_persistence <= bridge_wr_data[core_ctrl_pkg::persist_w-1:0]; // low nibble
      if (hit_overburn)
        cs_overburn <= bridge_wr_data[0];
      if (hit_show_bg)
        show_bg <= bridge_wr_data[0];
    end
  end

endmodule

`default_nettype wire

// File: source/input_sync.sv
/*
  Two-flop synchroniser for one controller word, any packed type.
*/
`timescale 1ns/1ps
`default_nettype none

module input_sync #(
  parameter type data_t = logic [31:0]
) (
  input  wire   clk_24,
  input  wire   rst_n,
  input  wire   data_t d, // async controller word
  output data_t q         // clk_24 domain copy
);

  data_t meta; // first stage, may go metastable

  always_ff @(posedge clk_24) begin
    if (!rst_n) begin
      meta <= '0;
      q    <= '0;
    end else begin
      meta <= d;
      q    <= meta;
    end
  end

endmodule

`default_nettype wire

// File: source/joy_map.sv
/*
  Joystick mapping for one controller. Face keys drive the core's
  direction buttons, stick or d-pad drives the two pots.
*/
`timescale 1ns/1ps
`default_nettype none

module joy_map (
  input  wire                       clk_24,
  input  wire                       rst_n,
  input  wire core_ctrl_pkg::cont_key_t key, // synchronised keys
  input  wire core_ctrl_pkg::cont_joy_t joy, // synchronised stick
  output logic                      up,
  output logic                      down,
  output logic                      left,
  output logic                      right,
  output core_ctrl_pkg::pot_t       pot_x,
  output core_ctrl_pkg::pot_t       pot_y
);

  core_ctrl_pkg::pot_t ana_x, ana_y; // stick terms
  core_ctrl_pkg::pot_t dig_x, dig_y; // d-pad terms
  logic has_analog;
  logic dpad_x, dpad_y;              // any d-pad bit on that axis

  //////////////////////////////////////////////////
  // stick and d-pad terms
  //////////////////////////////////////////////////
  assign ana_x = joy[7:0] + core_ctrl_pkg::pot_center;
  assign ana_y = ~(joy[15:8] + core_ctrl_pkg::pot_center); // core y axis runs the other way

  assign dig_x = {key[core_ctrl_pkg::key_right], {7{key[core_ctrl_pkg::key_left]}}};
  assign dig_y = {key[core_ctrl_pkg::key_down], {7{key[core_ctrl_pkg::key_up]}}};

  assign has_analog = (joy[15:0] != 16'h0); // stick off centre
  assign dpad_x = key[core_ctrl_pkg::key_left] | key[core_ctrl_pkg::key_right];
  assign dpad_y = key[core_ctrl_pkg::key_up] | key[core_ctrl_pkg::key_down];

  //////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk_24) begin
    if (!rst_n) begin
      up    <= 1'b0;
      down  <= 1'b0;
      left  <= 1'b0;
      right <= 1'b0;
      pot_x <= '0;
      pot_y <= '0;
    end else begin
      // face buttons act as the core's four buttons
      up    <= key[core_ctrl_pkg::key_x];
      down  <= key[core_ctrl_pkg::key_b];
      left  <= key[core_ctrl_pkg::key_y];
      right <= key[core_ctrl_pkg::key_a];
      // d-pad on an axis overrides the stick
      pot_x <= (has_analog && !dpad_x) ? ana_x : dig_x;
      pot_y <= (has_analog && !dpad_y) ? ana_y : dig_y;
    end
  end

endmodule

`default_nettype wire

// File: source/overlay_blend.sv
/*
  Overlay blend. Without beam the overlay is faded to black by its
  alpha; with beam the overlay colour (or the beam) shows, tinted
  towards white when the beam is bright. Purely combinational.
*/
`timescale 1ns/1ps
`default_nettype none

module overlay_blend (
  input  wire video_pkg::chan_t     beam_r,
  input  wire video_pkg::chan_t     beam_g,
  input  wire video_pkg::chan_t     beam_b,
  input  wire video_pkg::bg_pixel_t bg_pixel,
  input  wire                       show_bg,  // overlay enable
  output video_pkg::chan_t          mix_r,
  output video_pkg::chan_t          mix_g,
  output video_pkg::chan_t          mix_b
);

  //////////////////////////////////////////////////
  // alpha table, index {alpha, channel nibble}
  //////////////////////////////////////////////////
  typedef video_pkg::chan_t lut_t [256];

  function automatic lut_t build_alpha_lut();
    lut_t lut;
    int   chan;
    for (int i = 0; i < 256; i++) begin
      chan   = (i % 16) * 17; // nibble repeated into a byte
      lut[i] = video_pkg::chan_t'((chan * (i / 16)) / int'(video_pkg::alpha_max));
    end
    return lut;
  endfunction

  localparam lut_t alpha_lut = build_alpha_lut();

  // pull a channel about 3/4 of the way to white
  function automatic video_pkg::chan_t tint_white(input video_pkg::chan_t base);
    video_pkg::chan_t gap;
    gap = 8'd255 - base;
    return base + (gap >> 1) + (gap >> 2);
  endfunction

  video_pkg::bg_pixel_t bg;            // overlay after enable
  video_pkg::chan_t     exp_r, exp_g, exp_b;
  video_pkg::chan_t     base_r, base_g, base_b;
  video_pkg::chan_t     lit_r, lit_g, lit_b;
  video_pkg::chan_t     fade_r, fade_g, fade_b;
  logic beam_on;
  logic bg_present;
  logic bright;

  assign bg = show_bg ? bg_pixel : '0; // disabled overlay reads as empty

  // 4 to 8 bit expansion
  assign exp_r = {bg.r, bg.r};
  assign exp_g = {bg.g, bg.g};
  assign exp_b = {bg.b, bg.b};

  assign beam_on    = |{beam_r, beam_g, beam_b};
  assign bg_present = |{bg.r, bg.g, bg.b};      // alpha not counted
  assign bright     = (beam_r > video_pkg::tint_threshold);

  //////////////////////////////////////////////////
  // lit pixel, beam through overlay
  //////////////////////////////////////////////////
  assign base_r = bg_present ? exp_r : beam_r;
  assign base_g = bg_present ? exp_g : beam_g;
  assign base_b = bg_present ? exp_b : beam_b;

  assign lit_r = bright ? tint_white(base_r) : base_r;
  assign lit_g = bright ? tint_white(base_g) : base_g;
  assign lit_b = bright ? tint_white(base_b) : base_b;

  //////////////////////////////////////////////////
  // dark pixel, overlay faded by alpha
  //////////////////////////////////////////////////
  assign fade_r = alpha_lut[{bg.a, bg.r}];
  assign fade_g = alpha_lut[{bg.a, bg.g}];
  assign fade_b = alpha_lut[{bg.a, bg.b}];

  assign mix_r = beam_on ? lit_r : fade_r;
  assign mix_g = beam_on ? lit_g : fade_g;
  assign mix_b = beam_on ? lit_b : fade_b;

endmodule

`default_nettype wire

// File: source/vectrex_io_top.sv
/*
  Glue between vector core and handheld host: settings registers,
  controller sync and mapping, overlay blend and video output.
*/
`timescale 1ns/1ps
`default_nettype none

module vectrex_io_top (
  input  wire clk_24,
  input  wire rst_n,
  input  wire [31:0] bridge_addr,
  input  wire        bridge_wr,
  input  wire [31:0] bridge_wr_data,
  input  wire core_ctrl_pkg::cont_key_t cont1_key,
  input  wire core_ctrl_pkg::cont_key_t cont2_key,
  input  wire core_ctrl_pkg::cont_joy_t cont1_joy,
  input  wire core_ctrl_pkg::cont_joy_t cont2_joy,
  input  wire video_pkg::chan_t beam_r,
  input  wire video_pkg::chan_t beam_g,
  input  wire video_pkg::chan_t beam_b,
  input  wire video_pkg::bg_pixel_t bg_pixel, // aligned to beam pixel
  input  wire hblank,
  input  wire vblank,
  output logic [core_ctrl_pkg::persist_w-1:0] cs_persistence,
  output logic cs_overburn,
  output logic show_bg,
  output logic up_1, down_1, left_1, right_1,
  output core_ctrl_pkg::pot_t pot_x_1, pot_y_1,
  output logic up_2, down_2, left_2, right_2,
  output core_ctrl_pkg::pot_t pot_x_2, pot_y_2,
  output logic [23:0] video_rgb,
  output logic video_de, video_hs, video_vs
);

  core_ctrl_pkg::cont_key_t key1_s, key2_s; // clk_24 domain
  core_ctrl_pkg::cont_joy_t joy1_s, joy2_s;
  video_pkg::chan_t mix_r, mix_g, mix_b;

  //////////////////////////////////////////////////
  // settings
  //////////////////////////////////////////////////
  core_settings u_core_settings (.clk_24, .rst_n, .bridge_addr, .bridge_wr, .bridge_wr_data,
                                 .cs_persistence, .cs_overburn, .show_bg);

  //////////////////////////////////////////////////
  // controllers synced then mapped
  //////////////////////////////////////////////////
  input_sync #(.data_t(core_ctrl_pkg::cont_key_t)) u_sync_key1 (
    .clk_24, .rst_n, .d(cont1_key), .q(key1_s)
  );
  input_sync #(.data_t(core_ctrl_pkg::cont_key_t)) u_sync_key2 (
    .clk_24, .rst_n, .d(cont2_key), .q(key2_s)
  );
  input_sync #(.data_t(core_ctrl_pkg::cont_joy_t)) u_sync_joy1 (
    .clk_24, .rst_n, .d(cont1_joy), .q(joy1_s)
  );
  input_sync #(.data_t(core_ctrl_pkg::cont_joy_t)) u_sync_joy2 (
    .clk_24, .rst_n, .d(cont2_joy), .q(joy2_s)
  );

  joy_map u_joy_map_1 (.clk_24, .rst_n, .key(key1_s), .joy(joy1_s), .up(up_1), .down(down_1),
                       .left(left_1), .right(right_1), .pot_x(pot_x_1), .pot_y(pot_y_1));
  joy_map u_joy_map_2 (.clk_24, .rst_n, .key(key2_s), .joy(joy2_s), .up(up_2), .down(down_2),
                       .left(left_2), .right(right_2), .pot_x(pot_x_2), .pot_y(pot_y_2));

  //////////////////////////////////////////////////
  // video path
  //////////////////////////////////////////////////
  overlay_blend u_overlay_blend (.beam_r, .beam_g, .beam_b, .bg_pixel, .show_bg,
                                 .mix_r, .mix_g, .mix_b); // same cycle
  video_out u_video_out (.clk_24, .rst_n, .mix_r, .mix_g, .mix_b, .hblank, .vblank,
                         .video_rgb, .video_de, .video_hs, .video_vs);

endmodule

`default_nettype wire

// File: source/video_out.sv
/*
  Video output stage. Registers data enable and RGB, and turns the
  blank rising edges into one-cycle sync pulses.
*/
`timescale 1ns/1ps
`default_nettype none

module video_out (
  input  wire                   clk_24,
  input  wire                   rst_n,
  input  wire video_pkg::chan_t mix_r,
  input  wire video_pkg::chan_t mix_g,
  input  wire video_pkg::chan_t mix_b,
  input  wire                   hblank,
  input  wire                   vblank,
  output logic [23:0]           video_rgb, // r in top byte
  output logic                  video_de,
  output logic                  video_hs,
  output logic                  video_vs
);

  logic hblank_q, vblank_q; // blank levels one cycle back
  logic active;

  assign active = !(hblank || vblank);

  always_ff @(posedge clk_24) begin
    if (!rst_n) begin
      video_rgb <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      hblank_q  <= 1'b0;
      vblank_q  <= 1'b0;
    end else begin
      video_de  <= active;
      video_rgb <= active ? {mix_r, mix_g, mix_b} : 24'h0; // black in blanking
      // sync on blank rising edge
      video_hs  <= hblank && !hblank_q;
      video_vs  <= vblank && !vblank_q;
      hblank_q  <= hblank;
      vblank_q  <= vblank;
    end
  end

endmodule

`default_nettype wire

// File: source/video_pkg.sv
/*
  Video definitions: colour channel types, overlay pixel layout
  and the constants of the beam / overlay blend.
*/
`default_nettype none

package video_pkg;

  typedef logic [7:0] chan_t; // beam and output colour channel
  typedef logic [3:0] nib_t;  // overlay colour channel

  //////////////////////////////////////////////////
  // overlay pixel, RGBA 4:4:4:4
  //////////////////////////////////////////////////
  typedef struct packed {
    nib_t a; // alpha, top nibble
    nib_t b;
    nib_t g;
    nib_t r; // red, bottom nibble
  } bg_pixel_t;

  // beam red above this tints the colour towards white
  localparam chan_t tint_threshold = 8'd108;

  // alpha value for a fully opaque overlay
  localparam nib_t alpha_max = 4'd15;

endpackage

`default_nettype wire

// File: tb/tb_vectrex_io.sv
/*
  Testbench for the vector core glue. Clock, reset, random stimulus
  per test, watchdog, DUT and checker.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_vectrex_io;

  localparam int clk_period     = 8;
  localparam int drive_delay    = 1;  // ns after rising edge
  localparam int reset_cycles   = 4;
  localparam int drain_cycles   = 6;  // lets the 3 cycle joystick path empty
  localparam int n_settings     = 64;
  localparam int n_digital      = 150;
  localparam int n_analog       = 250;
  localparam int n_blend        = 400;
  localparam int n_blank        = 200;
  localparam int run_cycles     = reset_cycles + n_settings + n_digital + n_analog + n_blend +
                                  n_blank + 6 * drain_cycles + 2;
  localparam int timeout_cycles = run_cycles + 100;

  logic        clk_24;
  logic        rst_n;
  logic [31:0] bridge_addr;
  logic        bridge_wr;
  logic [31:0] bridge_wr_data;
  logic [31:0] cont1_key, cont2_key, cont1_joy, cont2_joy;
  logic [7:0]  beam_r, beam_g, beam_b;
  logic [15:0] bg_pixel;       // {a, b, g, r}
  logic        hblank, vblank;
  logic [core_ctrl_pkg::persist_w-1:0] cs_persistence;
  logic        cs_overburn, show_bg;
  logic        up_1, down_1, left_1, right_1, up_2, down_2, left_2, right_2;
  logic [7:0]  pot_x_1, pot_y_1, pot_x_2, pot_y_2;
  logic [23:0] video_rgb;
  logic        video_de, video_hs, video_vs;
  logic [7:0]  test_num;
  int          tests_passed, tests_failed, error_count;
  int          seed = 96;

  vectrex_io_top u_vectrex_io_top (.*);
  vectrex_io_checker u_checker (.*);

  initial begin
    clk_24 = 1'b0;
    forever #(clk_period / 2) clk_24 = ~clk_24;
  end

  //////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////
  task automatic step_cycle();
    @(posedge clk_24);
    #(drive_delay);
  endtask

  task automatic idle_inputs();
    bridge_wr = 1'b0;
    {bridge_addr, bridge_wr_data} = '0;
    {cont1_key, cont2_key, cont1_joy, cont2_joy} = '0;
    {beam_r, beam_g, beam_b, bg_pixel} = '0;
    {hblank, vblank} = 2'b00;
  endtask

  task automatic bridge_traffic();
    bridge_wr      = $random(seed);
    bridge_wr_data = $random(seed);
    case ($random(seed) & 3)
      0: bridge_addr = core_ctrl_pkg::addr_persistence;
      1: bridge_addr = core_ctrl_pkg::addr_overburn;
      2: bridge_addr = core_ctrl_pkg::addr_show_bg;
      default: bridge_addr = core_ctrl_pkg::addr_show_bg ^ (32'h1 << ($random(seed) & 31));
    endcase
  endtask

  task automatic beam_pixel();
    {beam_r, beam_g, beam_b} = $random(seed);
    if (($random(seed) & 3) == 0)
      {beam_r, beam_g, beam_b} = '0; // beam off so the overlay fades
    bg_pixel = $random(seed);
    if (($random(seed) & 3) == 0)
      bg_pixel[11:0] = '0;           // alpha only without overlay colour
  endtask

  task automatic stick_sample(output logic [31:0] key, output logic [31:0] joy);
    key = $random(seed);
    joy = $random(seed);
    if ($random(seed) & 1)
      key[3:2] = 2'b00;              // free x axis
    if ($random(seed) & 1)
      key[1:0] = 2'b00;              // free y axis
    if (($random(seed) & 3) == 0)
      joy[7:0] = 8'h00;
    if (joy[15:0] == 16'h0)
      joy[8] = 1'b1;                 // stick never centred here
  endtask

  task automatic finish_test(input logic [7:0] next);
    idle_inputs();
    repeat (drain_cycles) step_cycle();
    test_num = next;
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    idle_inputs();
    rst_n    = 1'b0;
    test_num = 8'd1;
    repeat (reset_cycles) begin     // outputs must stay zero whatever comes in
      bridge_traffic();
      beam_pixel();
      {cont1_key, cont2_key, cont1_joy, cont2_joy} = {$random(seed), $random(seed),
                                                      $random(seed), $random(seed)};
      step_cycle();
    end
    rst_n = 1'b1;
    finish_test(8'd2);
    repeat (n_settings) begin
      bridge_traffic();
      step_cycle();
    end
    finish_test(8'd3);
    repeat (n_digital) begin
      cont1_key = $random(seed);
      cont2_key = $random(seed);
      step_cycle();
    end
    finish_test(8'd4);
    repeat (n_analog) begin
      stick_sample(cont1_key, cont1_joy);
      stick_sample(cont2_key, cont2_joy);
      step_cycle();
    end
    finish_test(8'd5);
    for (int i = 0; i < n_blend; i++) begin
      beam_pixel();
      bridge_wr      = (i % 16 == 0); // flip overlay enable now and then
      bridge_addr    = core_ctrl_pkg::addr_show_bg;
      bridge_wr_data = $random(seed);
      step_cycle();
    end
    finish_test(8'd6);
    repeat (n_blank) begin
      beam_pixel();
      if (($random(seed) & 3) == 0)
        hblank = ~hblank;             // runs of a few cycles
      if (($random(seed) & 7) == 0)
        vblank = ~vblank;
      step_cycle();
    end
    finish_test(8'd7);
    repeat (2) step_cycle();          // checker closes the last test
    $display("tests passed %0d, tests failed %0d, value errors %0d",
             tests_passed, tests_failed, error_count);
    if (tests_failed == 0 && error_count == 0 && tests_passed == 6) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(timeout_cycles * clk_period);
    $display("watchdog expired, run did not finish within %0d cycles", timeout_cycles);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/vectrex_io_checker.sv
/*
  Checker for the vector core glue. Keeps a reference model of the
  settings, joystick and video paths, compares the DUT outputs every
  cycle and reports each test as it closes.
*/
`timescale 1ns/1ps
`default_nettype none

module vectrex_io_checker (
  input  wire        clk_24,
  input  wire        rst_n,
  input  wire [31:0] bridge_addr,
  input  wire        bridge_wr,
  input  wire [31:0] bridge_wr_data,
  input  wire [31:0] cont1_key, cont2_key, cont1_joy, cont2_joy,
  input  wire [7:0]  beam_r, beam_g, beam_b,
  input  wire [15:0] bg_pixel,
  input  wire        hblank, vblank,
  input  wire [core_ctrl_pkg::persist_w-1:0] cs_persistence,
  input  wire        cs_overburn, show_bg,
  input  wire        up_1, down_1, left_1, right_1,
  input  wire [7:0]  pot_x_1, pot_y_1,
  input  wire        up_2, down_2, left_2, right_2,
  input  wire [7:0]  pot_x_2, pot_y_2,
  input  wire [23:0] video_rgb,
  input  wire        video_de, video_hs, video_vs,
  input  wire [7:0]  test_num,     // current test from the stimulus side
  output int         tests_passed,
  output int         tests_failed,
  output int         error_count
);

  logic [5:0]  set_q;              // {persistence, overburn, show_bg}
  logic [31:0] k1_s1, k1_s2, j1_s1, j1_s2; // controller 1 sync stages
  logic [31:0] k2_s1, k2_s2, j2_s1, j2_s2;
  logic [19:0] joy1_q, joy2_q;     // {buttons, pot_x, pot_y}
  logic [26:0] vid_q;              // {de, hs, vs, rgb}
  logic        hb_q, vb_q;
  logic        primed;             // model holds a known state
  logic [7:0]  cur_test;
  int          test_errs;
  int          test_checks;

  //////////////////////////////////////////////////
  // reference functions
  //////////////////////////////////////////////////
  function automatic logic [5:0] settings_next(input logic [5:0] cur, input logic wr,
                                               input logic [31:0] addr, input logic [31:0] data);
    logic [5:0] nxt;
    nxt = cur;
    if (wr) begin
      case (addr)
        core_ctrl_pkg::addr_persistence: nxt[5:2] = data[3:0];
        core_ctrl_pkg::addr_overburn:    nxt[1]   = data[0];
        core_ctrl_pkg::addr_show_bg:     nxt[0]   = data[0];
        default: ;                       // unmapped, ignored
      endcase
    end
    return nxt;
  endfunction

  function automatic logic [19:0] joy_ref(input logic [31:0] key, input logic [31:0] joy);
    logic [7:0] ax, ay, dx, dy, px, py;
    logic       stick;
    ax = 8'((int'(joy[7:0]) + 128) % 256);
    ay = 8'(255 - (int'(joy[15:8]) + 128) % 256); // inverted y
    dx = (key[core_ctrl_pkg::key_right] ? 8'h80 : 8'h00) |
         (key[core_ctrl_pkg::key_left] ? 8'h7f : 8'h00);
    dy = (key[core_ctrl_pkg::key_down] ? 8'h80 : 8'h00) |
         (key[core_ctrl_pkg::key_up] ? 8'h7f : 8'h00);
    stick = (joy[15:0] != 16'h0);
    px = (stick && !key[core_ctrl_pkg::key_left] && !key[core_ctrl_pkg::key_right]) ? ax : dx;
    py = (stick && !key[core_ctrl_pkg::key_up] && !key[core_ctrl_pkg::key_down]) ? ay : dy;
    return {key[core_ctrl_pkg::key_x], key[core_ctrl_pkg::key_b],
            key[core_ctrl_pkg::key_y], key[core_ctrl_pkg::key_a], px, py};
  endfunction

  function automatic logic [23:0] blend_ref(input logic [7:0] r, input logic [7:0] g,
                                            input logic [7:0] b, input logic [15:0] px,
                                            input logic en);
    int beam[3];
    int nib[3];
    int ch[3];
    int alpha;
    int base;
    bit on;
    bit present;
    beam[0] = r;
    beam[1] = g;
    beam[2] = b;
    nib[0]  = en ? px[3:0] : 0;    // overlay off reads as empty
    nib[1]  = en ? px[7:4] : 0;
    nib[2]  = en ? px[11:8] : 0;
    alpha   = en ? px[15:12] : 0;
    on      = (r != 0) || (g != 0) || (b != 0);
    present = (nib[0] + nib[1] + nib[2]) != 0;
    for (int i = 0; i < 3; i++) begin
      if (on) begin
        base = present ? nib[i] * 17 : beam[i];
        if (r > 108)
          base = base + (255 - base) / 2 + (255 - base) / 4; // towards white
        ch[i] = base;
      end else begin
        ch[i] = (nib[i] * 17 * alpha) / 15; // faded overlay
      end
    end
    return {8'(ch[0]), 8'(ch[1]), 8'(ch[2])};
  endfunction

  function automatic string test_label(input logic [7:0] n);
    case (n)
      8'd1: return "reset";
      8'd2: return "settings";
      8'd3: return "digital joystick";
      8'd4: return "analog joystick";
      8'd5: return "overlay blend";
      8'd6: return "blanking";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    test_checks++;
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      test_errs++;
      error_count++;
    end
  endtask

  task automatic close_test();
    if (cur_test != 8'd0) begin
      if (test_errs == 0) begin
        tests_passed++;
        $display("test %0d %s: ok, %0d checks", cur_test, test_label(cur_test), test_checks);
      end else begin
        tests_failed++;
        $display("test %0d %s: %0d mismatches in %0d checks", cur_test,
                 test_label(cur_test), test_errs, test_checks);
      end
    end
    cur_test    = test_num;
    test_errs   = 0;
    test_checks = 0;
  endtask

  initial begin
    tests_passed = 0;
    tests_failed = 0;
    error_count  = 0;
    primed       = 1'b0;
    cur_test     = 8'd0;
    test_errs    = 0;
    test_checks  = 0;
  end

  //////////////////////////////////////////////////
  // compare, then step the model, on falling edge
  //////////////////////////////////////////////////
  always @(negedge clk_24) begin
    if (primed) begin
      check_value("cs_persistence", set_q[5:2], cs_persistence);
      check_value("cs_overburn", set_q[1], cs_overburn);
      check_value("show_bg", set_q[0], show_bg);
      check_value("{up_1,down_1,left_1,right_1}", joy1_q[19:16], {up_1, down_1, left_1, right_1});
      check_value("pot_x_1", joy1_q[15:8], pot_x_1);
      check_value("pot_y_1", joy1_q[7:0], pot_y_1);
      check_value("{up_2,down_2,left_2,right_2}", joy2_q[19:16], {up_2, down_2, left_2, right_2});
      check_value("pot_x_2", joy2_q[15:8], pot_x_2);
      check_value("pot_y_2", joy2_q[7:0], pot_y_2);
      check_value("video_de", vid_q[26], video_de);
      check_value("video_hs", vid_q[25], video_hs);
      check_value("video_vs", vid_q[24], video_vs);
      check_value("video_rgb", vid_q[23:0], video_rgb);
    end
    if (!rst_n) begin
      set_q  = '0;
      vid_q  = '0;
      hb_q   = 1'b0;
      vb_q   = 1'b0;
      joy1_q = '0;
      joy2_q = '0;
      {k1_s1, k1_s2, j1_s1, j1_s2} = '0;
      {k2_s1, k2_s2, j2_s1, j2_s2} = '0;
    end else begin
      // video uses show_bg as it stands before this cycle's write
      vid_q[26]   = !(hblank || vblank);
      vid_q[25]   = hblank && !hb_q;
      vid_q[24]   = vblank && !vb_q;
      vid_q[23:0] = vid_q[26] ? blend_ref(beam_r, beam_g, beam_b, bg_pixel, set_q[0]) : 24'h0;
      hb_q        = hblank;
      vb_q        = vblank;
      set_q       = settings_next(set_q, bridge_wr, bridge_addr, bridge_wr_data);
      joy1_q = joy_ref(k1_s2, j1_s2); // sync 2 + map 1
      joy2_q = joy_ref(k2_s2, j2_s2);
      k1_s2  = k1_s1;
      j1_s2  = j1_s1;
      k1_s1  = cont1_key;
      j1_s1  = cont1_joy;
      k2_s2  = k2_s1;
      j2_s2  = j2_s1;
      k2_s1  = cont2_key;
      j2_s1  = cont2_joy;
    end
    primed = 1'b1;
    if (test_num != cur_test)
      close_test();
  end

endmodule

`default_nettype wire
